/* dv/excGolden.txt */
# test valid pc flags regsWr badAddr hwIntr wrEn wrAddr wrData rdAddr care, then expected excCode entrySel regsWrFinal excVector flush cp0Epc cp0RdData
# all hex, one line per cycle; care bits 0..6 enable excCode, entrySel, regsWrFinal, excVector, flush, cp0Epc, cp0RdData
1 1 80001000 00881 7 00000000 00 0 00 00000000 0c 5f 08 1 0 bfc00380 1 00000000 00400000
1 0 80001004 3ffff 5 00000000 00 0 00 00000000 0d 7f 00 0 5 bfc00380 0 80001000 00000020
1 1 80001008 30200 1 00000000 00 0 00 00000000 0c 7f 02 3 1 bfc00380 0 80001000 00400002
2 1 80002000 00200 7 00000000 00 0 00 00000000 0c 7f 0a 2 0 bfc00380 1 80001000 00400002
2 1 80002004 00500 2 00000000 00 0 00 00000000 0c 7f 09 1 0 bfc00380 1 80001000 00400000
2 1 80002008 00080 4 00000000 00 0 00 00000000 0d 7f 0c 1 0 bfc00380 1 80002004 00000024
3 1 8000200c 00040 3 12345679 00 0 00 00000000 0e 7f 0d 1 0 bfc00380 1 80002008 80002008
3 1 80003002 00000 1 00000000 00 0 00 00000000 08 7f 03 1 0 bfc00380 1 8000200c 12345679
3 0 80003004 00000 3 00000000 00 0 00 00000000 08 7f 00 0 3 bfc00380 0 80003002 80003002
4 0 80003008 00000 0 00000000 00 1 0c 00000002 0d 7f 00 0 0 bfc00380 0 80003002 00000010
4 0 8000300c 00000 0 00000000 00 1 0f 90000000 0c 7f 00 0 0 80000180 0 80003002 00000002
4 1 80004000 08000 7 00000000 00 0 00 00000000 0f 7f 04 1 0 90000180 1 80003002 90000000
4 1 80004004 00200 0 00000000 00 0 00 00000000 08 7f 0a 2 0 90000180 1 80004000 80004000
4 1 80004008 00010 0 0000abcd 00 0 00 00000000 0c 7f 0f 1 0 90000000 1 80004000 00000000
5 0 8000400c 00000 0 00000000 00 1 0c 00000401 08 7f 00 0 0 90000180 0 80004008 0000abcd
5 1 80005000 00000 1 00000000 01 0 00 00000000 0c 7f 00 0 1 90000180 0 80004008 00000401
5 1 80005004 00000 1 00000000 01 0 00 00000000 0d 7f 01 1 0 90000180 1 80004008 00000408
5 1 80005008 00000 1 00000000 01 0 00 00000000 0c 7f 00 0 1 90000180 0 80005004 00000403
5 0 8000500c 00000 0 00000000 01 1 0c 00000101 0d 7f 00 0 0 90000180 0 80005004 00000400
5 1 80005010 00000 2 00000000 01 1 0d 00000100 0c 7f 00 0 2 90000180 0 80005004 00000101
5 1 80005014 00000 2 00000000 00 0 00 00000000 0d 7f 01 1 0 90000180 1 80005004 00000500
6 0 80006000 00000 0 00000000 00 1 0d 00000000 0e 7f 00 0 0 90000180 0 80005014 80005014
6 0 80006000 00000 0 00000000 00 1 0c 00008001 0d 7f 00 0 0 90000180 0 80005014 00000000
6 0 80006000 00000 0 00000000 00 1 0b 0000001a 09 7f 00 0 0 90000180 0 80005014 00000017
6 1 80006000 00000 4 00000000 00 0 00 00000000 09 7f 00 0 4 90000180 0 80005014 00000018
6 1 80006004 00000 4 00000000 00 0 00 00000000 09 7f 00 0 4 90000180 0 80005014 00000019
6 1 80006008 00000 4 00000000 00 0 00 00000000 09 7f 00 0 4 90000180 0 80005014 0000001a
6 1 8000600c 00000 4 00000000 00 0 00 00000000 0d 7f 01 1 0 90000180 1 80005014 40008000
6 0 80006010 00000 0 00000000 00 1 0b 00000100 0d 7f 00 0 0 90000180 0 8000600c 40008000
6 0 80006014 00000 0 00000000 00 0 00 00000000 0d 7f 00 0 0 90000180 0 8000600c 00000000

/* excTop.f */
common/cpuPkg.sv
common/cp0Pkg.sv
common/cp0If.sv
hw/exception/excPrioritizer.sv
hw/cp0/cp0Regs.sv
hw/excTop.sv
dv/excTb.sv

/* Bender.yml */
package:
  name: exc_stage

sources:
  - common/cpuPkg.sv
  - common/cp0Pkg.sv
  - common/cp0If.sv
  - hw/exception/excPrioritizer.sv
  - hw/cp0/cp0Regs.sv
  - hw/excTop.sv
  - target: simulation
    files:
      - dv/excTb.sv

/* dv/excTb.sv */
/* excTb
   replays golden vectors through the exception stage and checks
   the combinational outputs and the CP0 read port */
`timescale 1ns/1ps
`default_nettype none

module excTb
    import cpuPkg::*;
    import cp0Pkg::*;
();

    localparam int MAX_LINES  = 500;
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        rstN;
    logic        memValid;
    logic [31:0] memPc;
    excFlagsT    memExcFlags;
    regsWrT      memRegsWr;
    logic [31:0] memBadAddr;
    logic [5:0]  hwIntr;
    logic        cp0WrEn;
    cp0RegE      cp0WrAddr;
    logic [31:0] cp0WrData;
    cp0RegE      cp0RdAddr;
    excCodeE     excCode;
    entrySelE    entrySel;
    regsWrT      regsWrFinal;
    logic [31:0] excVector;
    logic        flush;
    logic [31:0] cp0Epc;
    logic [31:0] cp0RdData;

    logic [31:0] vec [0:18];   // one parsed golden line
    int errCount = 0;
    int checkCount = 0;
    int vecCount = 0;
    int curTest = -1;
    int testVecs = 0;
    int testErrs = 0;
    int lineNo = 0;

    excTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        int cyc;
        cyc = 0;
        while (cyc < MAX_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        $display("simulation timed out after %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            testErrs++;
            $display("CHECK FAILED %s got %h expected %h (test %0d, line %0d)",
                     name, got, exp, curTest, lineNo);
        end
    endtask

    task automatic finishTest();
        $display("test %0d finished: %0d vectors, %0d errors", curTest, testVecs, testErrs);
    endtask

    task automatic driveInputs();
        memValid = vec[1][0];
        memPc = vec[2];
        memExcFlags = excFlagsT'(vec[3][17:0]);
        memRegsWr = regsWrT'(vec[4][2:0]);
        // bad address only matters for MEM-stage faults
        memBadAddr = (vec[3][6:0] != 7'h00) ? vec[5] : $urandom;
        hwIntr = vec[6][5:0];
        cp0WrEn = vec[7][0];
        cp0WrAddr = cp0RegE'(vec[8][4:0]);
        cp0WrData = vec[9];
        cp0RdAddr = cp0RegE'(vec[10][4:0]);
    endtask

    task automatic checkOutputs();
        if (vec[11][0]) checkVal("excCode", excCode, vec[12]);
        if (vec[11][1]) checkVal("entrySel", entrySel, vec[13]);
        if (vec[11][2]) checkVal("regsWrFinal", regsWrFinal, vec[14]);
        if (vec[11][3]) checkVal("excVector", excVector, vec[15]);
        if (vec[11][4]) checkVal("flush", flush, vec[16]);
        if (vec[11][5]) checkVal("cp0Epc", cp0Epc, vec[17]);
        if (vec[11][6]) checkVal("cp0RdData", cp0RdData, vec[18]);
    endtask

    task automatic replayVectors(input int fd);
        string line;
        int n;
        int guard;
        bit atEnd;
        guard = 0;
        atEnd = 0;
        while (!atEnd && guard < MAX_LINES) begin
            guard++;
            if ($fgets(line, fd) == 0) begin
                atEnd = 1;
            end else begin
                lineNo++;
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                vec[0], vec[1], vec[2], vec[3], vec[4], vec[5], vec[6],
                                vec[7], vec[8], vec[9], vec[10], vec[11], vec[12],
                                vec[13], vec[14], vec[15], vec[16], vec[17], vec[18]);
                    if (n != 19) begin
                        $display("golden line %0d is malformed, only %0d fields read", lineNo, n);
                        errCount++;
                    end else begin
                        if (vec[0] != curTest) begin
                            if (curTest >= 0)
                                finishTest();
                            curTest = vec[0];
                            testVecs = 0;
                            testErrs = 0;
                        end
                        driveInputs();
                        #6;   // just before the next rising edge
                        checkOutputs();
                        vecCount++;
                        testVecs++;
                        @(posedge clk);
                        #1;
                    end
                end
            end
        end
        if (!atEnd) begin
            $display("reading the golden file did not end within %0d lines", MAX_LINES);
            errCount++;
        end
        if (curTest >= 0)
            finishTest();
    endtask

    initial begin
        int fd;
        int seedVal;
        seedVal = $urandom(32'hef29);
        rstN = 1'b0;
        memValid = 1'b0;
        memPc = '0;
        memExcFlags = '0;
        memRegsWr = '0;
        memBadAddr = '0;
        hwIntr = '0;
        cp0WrEn = 1'b0;
        cp0WrAddr = STATUS;
        cp0WrData = '0;
        cp0RdAddr = STATUS;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;   // first vector goes out with the reset release
        fd = $fopen("dv/excGolden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden vector file dv/excGolden.txt");
            errCount++;
        end else begin
            replayVectors(fd);
            $fclose(fd);
        end
        if (vecCount == 0) begin
            $display("no vectors were applied");
            errCount++;
        end
        $display("vectors %0d, checks %0d, errors %0d", vecCount, checkCount, errCount);
        if (errCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/excTop.sv */
/* excTop
   exception stage top, prioritizer and CP0 block on plain ports */
`timescale 1ns/1ps
`default_nettype none

module excTop
    import cpuPkg::*;
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        memValid,
    input  logic [31:0] memPc,
    input  excFlagsT    memExcFlags,
    input  regsWrT      memRegsWr,
    input  logic [31:0] memBadAddr,
    input  logic [5:0]  hwIntr,
    input  logic        cp0WrEn,
    input  cp0RegE      cp0WrAddr,
    input  logic [31:0] cp0WrData,
    input  cp0RegE      cp0RdAddr,
    output excCodeE     excCode,
    output entrySelE    entrySel,
    output regsWrT      regsWrFinal,
    output logic [31:0] excVector,
    output logic        flush,
    output logic [31:0] cp0Epc,
    output logic [31:0] cp0RdData
);

    cp0If cp0Bus ();

    excPrioritizer prio_i (
        .memValid    (memValid),
        .memPc       (memPc),
        .memExcFlags (memExcFlags),
        .memRegsWr   (memRegsWr),
        .memBadAddr  (memBadAddr),
        .cp0         (cp0Bus.excp),
        .excCode     (excCode),
        .entrySel    (entrySel),
        .regsWrFinal (regsWrFinal),
        .excVector   (excVector),
        .flush       (flush)
    );

    cp0Regs cp0_i (
        .clk       (clk),
        .rstN      (rstN),
        .hwIntr    (hwIntr),
        .cp0WrEn   (cp0WrEn),
        .cp0WrAddr (cp0WrAddr),
        .cp0WrData (cp0WrData),
        .cp0RdAddr (cp0RdAddr),
        .cp0RdData (cp0RdData),
        .epc       (cp0Epc),
        .cp0       (cp0Bus.regs)
    );

endmodule

`default_nettype wire

/* hw/cp0/cp0Regs.sv */
/* cp0Regs
   CP0 registers with mtc0/mfc0 access, exception and eret updates,
   and the count/compare timer interrupt */
`timescale 1ns/1ps
`default_nettype none

module cp0Regs
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic [5:0]  hwIntr,
    input  logic        cp0WrEn,
    input  cp0RegE      cp0WrAddr,
    input  logic [31:0] cp0WrData,
    input  cp0RegE      cp0RdAddr,
    output logic [31:0] cp0RdData,
    output logic [31:0] epc,
    cp0If.regs          cp0
);

    logic [31:0] status;
    logic [31:0] ebase;
    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] badVAddr;
    logic [5:0]  hwIp;        // registered hwIntr
    logic [1:0]  swIp;        // software interrupt bits
    logic        timerInt;
    logic [4:0]  causeCode;
    logic [7:0]  ip;
    logic [31:0] cause;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            status <= STATUS_RESET;
            ebase <= EBASE_RESET;
            count <= '0;
            compare <= COMPARE_RESET;
            hwIp <= '0;
            swIp <= '0;
            timerInt <= 1'b0;
            causeCode <= '0;
        end else begin
            count <= count + 32'd1;
            hwIp <= hwIntr;
            if (count == compare)
                timerInt <= 1'b1;

            if (cp0WrEn) begin
                case (cp0WrAddr)
                    COUNT:   count <= cp0WrData;
                    COMPARE: begin
                        compare <= cp0WrData;
                        timerInt <= 1'b0;   // ack of the timer
                    end
                    STATUS:  status <= (status & ~STATUS_WMASK) | (cp0WrData & STATUS_WMASK);
                    CAUSE:   swIp <= cp0WrData[9:8];
                    EBASE:   ebase <= (ebase & ~EBASE_WMASK) | (cp0WrData & EBASE_WMASK);
                    default: ;
                endcase
            end

            // exception event wins over a same-cycle mtc0
            if (cp0.excTake) begin
                status[1] <= 1'b1;
                causeCode <= cp0.excCause;
            end else if (cp0.eretTake) begin
                status[1] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cp0WrEn && cp0WrAddr == EPC)
            epc <= cp0WrData;
        if (cp0.excTake)
            epc <= cp0.excEpc;
        if (cp0.excTake && cp0.badVAddrWr)
            badVAddr <= cp0.badVAddr;
    end

    assign ip = {hwIp[5] | timerInt, hwIp[4:0], swIp};   // timer shares IP7
    assign cause = {1'b0, timerInt, 14'b0, ip, 1'b0, causeCode, 2'b00};

    always_comb begin
        case (cp0RdAddr)
            BADVADDR: cp0RdData = badVAddr;
            COUNT:    cp0RdData = count;
            COMPARE:  cp0RdData = compare;
            STATUS:   cp0RdData = status;
            CAUSE:    cp0RdData = cause;
            EPC:      cp0RdData = epc;
            EBASE:    cp0RdData = ebase;
            default:  cp0RdData = '0;
        endcase
    end

    assign cp0.bev = status[22];
    assign cp0.im = status[15:8];
    assign cp0.exl = status[1];
    assign cp0.ie = status[0];
    assign cp0.ip = ip;
    assign cp0.ebase = ebase;

endmodule

`default_nettype wire

/* hw/exception/excPrioritizer.sv */
/* excPrioritizer
   resolves MEM-stage exception flags and interrupts into one exception,
   then derives flush, write squash, entry select and handler vector */
`timescale 1ns/1ps
`default_nettype none

module excPrioritizer
    import cpuPkg::*;
    import cp0Pkg::*;
(
    input  logic        memValid,
    input  logic [31:0] memPc,
    input  excFlagsT    memExcFlags,
    input  regsWrT      memRegsWr,
    input  logic [31:0] memBadAddr,
    cp0If.excp          cp0,
    output excCodeE     excCode,
    output entrySelE    entrySel,
    output regsWrT      regsWrFinal,
    output logic [31:0] excVector,
    output logic        flush
);

    excFlagsT    flagsV;
    logic        intrTake;
    logic        refill;
    logic [31:0] base;
    logic [31:0] offset;

    assign intrTake = memValid && ((cp0.ip & cp0.im) != 8'h00) && !cp0.exl && cp0.ie;

    always_comb begin
        flagsV = memValid ? memExcFlags : '0;
        flagsV.wrongAddrIf = memValid && (memExcFlags.wrongAddrIf || memPc[1:0] != 2'b00);
    end

    // MIPS priority order, interrupt first
    always_comb begin
        if (intrTake)                      excCode = EXC_INT;
        else if (flagsV.refetch)           excCode = EXC_REFETCH;
        else if (flagsV.wrongAddrIf)       excCode = EXC_ADEL_IF;
        else if (flagsV.tlbRefillIf)       excCode = EXC_REFILL_IF;
        else if (flagsV.tlbInvalidIf)      excCode = EXC_INVALID_IF;
        else if (flagsV.cpUnusable)        excCode = EXC_CPU;
        else if (flagsV.reservedInstr)     excCode = EXC_RI;
        else if (flagsV.syscall)           excCode = EXC_SYS;
        else if (flagsV.breakInstr)        excCode = EXC_BP;
        else if (flagsV.eret)              excCode = EXC_ERET;
        else if (flagsV.trap)              excCode = EXC_TRAP;
        else if (flagsV.overflow)          excCode = EXC_OV;
        else if (flagsV.wrWrongAddrMem)    excCode = EXC_ADES_MEM;
        else if (flagsV.rdWrongAddrMem)    excCode = EXC_ADEL_MEM;
        else if (flagsV.rdTlbRefillMem)    excCode = EXC_REFILL_LD;
        else if (flagsV.wrTlbRefillMem)    excCode = EXC_REFILL_ST;
        else if (flagsV.rdTlbInvalidMem)   excCode = EXC_INVALID_LD;
        else if (flagsV.wrTlbInvalidMem)   excCode = EXC_INVALID_ST;
        else if (flagsV.tlbModified)       excCode = EXC_MOD;
        else                               excCode = EXC_NONE;
    end

    always_comb begin
        if (excCode == EXC_NONE || excCode == EXC_REFETCH) begin
            regsWrFinal = memRegsWr;
            flush = 1'b0;
        end else begin
            regsWrFinal = '0;   // squash the faulting write
            flush = 1'b1;
        end
    end

    always_comb begin
        case (excCode)
            EXC_NONE:    entrySel = ENTRY_NONE;
            EXC_REFETCH: entrySel = ENTRY_REFETCH;
            EXC_ERET:    entrySel = ENTRY_ERET;
            default:     entrySel = ENTRY_EXC;
        endcase
    end

    // architectural code for Cause
    always_comb begin
        case (excCode)
            EXC_INT:                                      cp0.excCause = EXCCODE_INT;
            EXC_ADEL_IF, EXC_ADEL_MEM:                    cp0.excCause = EXCCODE_ADEL;
            EXC_ADES_MEM:                                 cp0.excCause = EXCCODE_ADES;
            EXC_REFILL_IF, EXC_INVALID_IF,
            EXC_REFILL_LD, EXC_INVALID_LD:                cp0.excCause = EXCCODE_TLBL;
            EXC_REFILL_ST, EXC_INVALID_ST:                cp0.excCause = EXCCODE_TLBS;
            EXC_MOD:                                      cp0.excCause = EXCCODE_MOD;
            EXC_CPU:                                      cp0.excCause = EXCCODE_CPU;
            EXC_RI:                                       cp0.excCause = EXCCODE_RI;
            EXC_SYS:                                      cp0.excCause = EXCCODE_SYS;
            EXC_BP:                                       cp0.excCause = EXCCODE_BP;
            EXC_TRAP:                                     cp0.excCause = EXCCODE_TR;
            EXC_OV:                                       cp0.excCause = EXCCODE_OV;
            default:                                      cp0.excCause = EXCCODE_INT;
        endcase
    end

    // faulting address for BadVAddr
    always_comb begin
        case (excCode)
            EXC_ADEL_IF, EXC_REFILL_IF, EXC_INVALID_IF: begin
                cp0.badVAddrWr = 1'b1;
                cp0.badVAddr = memPc;
            end
            EXC_ADES_MEM, EXC_ADEL_MEM, EXC_REFILL_LD, EXC_REFILL_ST,
            EXC_INVALID_LD, EXC_INVALID_ST, EXC_MOD: begin
                cp0.badVAddrWr = 1'b1;
                cp0.badVAddr = memBadAddr;
            end
            default: begin
                cp0.badVAddrWr = 1'b0;
                cp0.badVAddr = memBadAddr;
            end
        endcase
    end

    assign cp0.excTake = !(excCode inside {EXC_NONE, EXC_REFETCH, EXC_ERET});
    assign cp0.eretTake = excCode == EXC_ERET;
    assign cp0.excEpc = memPc;   // interrupts also restart at the MEM pc

    assign refill = excCode inside {EXC_REFILL_IF, EXC_REFILL_LD, EXC_REFILL_ST};
    assign base = cp0.bev ? BOOT_EXC_BASE : cp0.ebase;
    assign offset = (refill && !cp0.exl) ? REFILL_OFFSET : GENERAL_OFFSET;
    assign excVector = base + offset;

endmodule

`default_nettype wire

/* common/cp0If.sv */
/* cp0If
   CP0 status view toward the prioritizer, exception events back to CP0 */
`timescale 1ns/1ps
`default_nettype none

interface cp0If;

    logic        bev;
    logic        exl;
    logic        ie;
    logic [7:0]  im;
    logic [7:0]  ip;
    logic [31:0] ebase;

    logic        excTake;      // level, sampled at the next clk edge
    logic [4:0]  excCause;     // architectural ExcCode
    logic [31:0] excEpc;
    logic        badVAddrWr;
    logic [31:0] badVAddr;
    logic        eretTake;

    modport regs (
        output bev, exl, ie, im, ip, ebase,
        input  excTake, excCause, excEpc, badVAddrWr, badVAddr, eretTake
    );

    modport excp (
        input  bev, exl, ie, im, ip, ebase,
        output excTake, excCause, excEpc, badVAddrWr, badVAddr, eretTake
    );

endinterface

`default_nettype wire

/* common/cp0Pkg.sv */
/* cp0Pkg
   coprocessor-0 register map, reset values, vectors and ExcCode values */
`default_nettype none

package cp0Pkg;

    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        EBASE    = 5'd15
    } cp0RegE;

    localparam logic [31:0] STATUS_RESET  = 32'h0040_0000;   // BEV=1, EXL=0, IE=0
    localparam logic [31:0] STATUS_WMASK  = 32'h0040_ff03;   // BEV, IM, EXL, IE
    localparam logic [31:0] EBASE_RESET   = 32'h8000_0000;
    localparam logic [31:0] EBASE_WMASK   = 32'h3fff_f000;   // exception base field
    localparam logic [31:0] COMPARE_RESET = 32'hffff_ffff;   // far from count at reset

    localparam logic [31:0] BOOT_EXC_BASE  = 32'hbfc0_0200;
    localparam logic [31:0] GENERAL_OFFSET = 32'h0000_0180;
    localparam logic [31:0] REFILL_OFFSET  = 32'h0000_0000;

    // architectural Cause.ExcCode
    localparam logic [4:0] EXCCODE_INT  = 5'h00;
    localparam logic [4:0] EXCCODE_MOD  = 5'h01;
    localparam logic [4:0] EXCCODE_TLBL = 5'h02;
    localparam logic [4:0] EXCCODE_TLBS = 5'h03;
    localparam logic [4:0] EXCCODE_ADEL = 5'h04;
    localparam logic [4:0] EXCCODE_ADES = 5'h05;
    localparam logic [4:0] EXCCODE_SYS  = 5'h08;
    localparam logic [4:0] EXCCODE_BP   = 5'h09;
    localparam logic [4:0] EXCCODE_RI   = 5'h0a;
    localparam logic [4:0] EXCCODE_CPU  = 5'h0b;
    localparam logic [4:0] EXCCODE_OV   = 5'h0c;
    localparam logic [4:0] EXCCODE_TR   = 5'h0d;

endpackage

`default_nettype wire

/* common/cpuPkg.sv */
/* cpuPkg
   pipeline-side types shared by the exception stage */
`default_nettype none

package cpuPkg;

    // exception flags collected by the earlier stages, highest priority first
    typedef struct packed {
        logic refetch;
        logic wrongAddrIf;
        logic tlbRefillIf;
        logic tlbInvalidIf;
        logic cpUnusable;
        logic reservedInstr;
        logic syscall;
        logic breakInstr;      // break is a keyword
        logic eret;
        logic trap;
        logic overflow;
        logic wrWrongAddrMem;
        logic rdWrongAddrMem;
        logic rdTlbRefillMem;
        logic wrTlbRefillMem;
        logic rdTlbInvalidMem;
        logic wrTlbInvalidMem;
        logic tlbModified;
    } excFlagsT;

    typedef struct packed {
        logic regWr;
        logic hiWr;
        logic loWr;
    } regsWrT;

    // internal ranking, not the Cause.ExcCode value
    typedef enum logic [4:0] {
        EXC_NONE,
        EXC_INT,
        EXC_REFETCH,
        EXC_ADEL_IF,
        EXC_REFILL_IF,
        EXC_INVALID_IF,
        EXC_CPU,
        EXC_RI,
        EXC_SYS,
        EXC_BP,
        EXC_ERET,
        EXC_TRAP,
        EXC_OV,
        EXC_ADES_MEM,
        EXC_ADEL_MEM,
        EXC_REFILL_LD,
        EXC_REFILL_ST,
        EXC_INVALID_LD,
        EXC_INVALID_ST,
        EXC_MOD
    } excCodeE;

    typedef enum logic [1:0] {
        ENTRY_NONE,
        ENTRY_EXC,
        ENTRY_ERET,
        ENTRY_REFETCH
    } entrySelE;

endpackage

`default_nettype wire
